// File: lsu.f
+incdir+include
verilog/lsu_pkg.sv
verilog/lsu_addr_gen.sv
verilog/lsu_txn_tracker.sv
verilog/lsu_rdata_align.sv
verilog/lsu_top.sv
verif/lsu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the load/store unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/10ps --top-module lsu_tb -f lsu.f -o lsu_sim \
  && ./obj_dir/lsu_sim | tee /dev/stderr | grep -q "Verification passed" \
  && echo "simulation result: pass" \
  || { echo "simulation result: fail"; exit 1; }

// File: include/lsu_tb_ref.svh
//////////////////////////////////////////////////////////////////////
// Load/store reference model
//////////////////////////////////////////////////////////////////////

`ifndef LSU_TB_REF_SVH
`define LSU_TB_REF_SVH

// Expected load value from the word at the address and the one after it
function automatic logic [lsu_pkg::DATA_W-1:0] ref_load(
  input logic [lsu_pkg::DATA_W-1:0] lo_word,
  input logic [lsu_pkg::DATA_W-1:0] hi_word,
  input logic [lsu_pkg::OFFS_W-1:0] offs,
  input logic [lsu_pkg::TYPE_W-1:0] typ,
  input logic                       sign_ext
);
  logic [2*lsu_pkg::DATA_W-1:0] pair;
  logic [lsu_pkg::DATA_W-1:0]   raw;
  pair = {hi_word, lo_word} >> {offs, 3'b000};
  raw  = pair[lsu_pkg::DATA_W-1:0];
  case (typ)
    lsu_pkg::LSU_BYTE: return {{(lsu_pkg::DATA_W-8){sign_ext & raw[7]}}, raw[7:0]};
    lsu_pkg::LSU_HALF: return {{(lsu_pkg::DATA_W-16){sign_ext & raw[15]}}, raw[15:0]};
    default:           return raw;
  endcase
endfunction

// Expected enables, second selects the follow-up word of a split
function automatic logic [lsu_pkg::BE_W-1:0] ref_be(
  input logic [lsu_pkg::TYPE_W-1:0] typ,
  input logic [lsu_pkg::OFFS_W-1:0] offs,
  input logic                       second
);
  logic [2*lsu_pkg::BE_W-1:0] mask;
  case (typ)
    lsu_pkg::LSU_BYTE: mask = 8'b0000_0001;
    lsu_pkg::LSU_HALF: mask = 8'b0000_0011;
    default:           mask = 8'b0000_1111;
  endcase
  mask = mask << offs;
  return second ? mask[2*lsu_pkg::BE_W-1:lsu_pkg::BE_W] : mask[lsu_pkg::BE_W-1:0];
endfunction

`endif

// File: verif/lsu_tb.sv
//////////////////////////////////////////////////////////////////////
// Load/store unit testbench
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_tb;

  localparam int MAX_OUT = lsu_pkg::DEF_MAX_OUTSTANDING;
  localparam int TIMEOUT = 200;

  logic                       clk;
  logic                       rst_n;
  logic                       req_i;
  logic [lsu_pkg::ADDR_W-1:0] base_i;
  logic [lsu_pkg::ADDR_W-1:0] offset_i;
  logic [lsu_pkg::TYPE_W-1:0] type_i;
  logic                       sign_ext_i;
  logic                       we_i;
  logic [lsu_pkg::DATA_W-1:0] wdata_i;
  logic                       ready_o;
  logic                       busy_o;
  logic                       result_valid_o;
  logic [lsu_pkg::DATA_W-1:0] rdata_o;
  logic                       err_o;
  logic                       data_req_o;
  logic                       data_gnt_i;
  logic [lsu_pkg::ADDR_W-1:0] data_addr_o;
  logic                       data_we_o;
  logic [lsu_pkg::BE_W-1:0]   data_be_o;
  logic [lsu_pkg::DATA_W-1:0] data_wdata_o;
  logic                       data_rvalid_i;
  logic [lsu_pkg::DATA_W-1:0] data_rdata_i;
  logic                       data_err_i;

  // Memory model contents and the expected view of it
  logic [lsu_pkg::DATA_W-1:0] mem [256];
  logic [lsu_pkg::DATA_W-1:0] shadow [256];

  // Expected bus phases, in grant order
  logic [lsu_pkg::ADDR_W-1:0] exp_addr_q [$];
  logic [lsu_pkg::BE_W-1:0]   exp_be_q [$];
  // Expected error flag per bus phase
  logic                       exp_err_q [$];
  // Expected results, in access order
  logic                       exp_we_q [$];
  logic [lsu_pkg::DATA_W-1:0] exp_data_q [$];
  // Granted accesses waiting for their response
  int                         rsp_due_q [$];
  logic [lsu_pkg::DATA_W-1:0] rsp_data_q [$];
  logic                       rsp_err_q [$];

  integer seed = 56425;
  int     cycle = 0;
  int     gnt_wait = 0;
  int     outstanding = 0;
  int     accesses = 0;
  int     results = 0;
  logic   err_next = 1'b0;

  `include "lsu_tb_ref.svh"

  lsu_top #(
    .MAX_OUTSTANDING (MAX_OUT)
  ) lsu_top_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .base_i         (base_i),
    .offset_i       (offset_i),
    .type_i         (type_i),
    .sign_ext_i     (sign_ext_i),
    .we_i           (we_i),
    .wdata_i        (wdata_i),
    .ready_o        (ready_o),
    .busy_o         (busy_o),
    .result_valid_o (result_valid_o),
    .rdata_o        (rdata_o),
    .err_o          (err_o),
    .data_req_o     (data_req_o),
    .data_gnt_i     (data_gnt_i),
    .data_addr_o    (data_addr_o),
    .data_we_o      (data_we_o),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o),
    .data_rvalid_i  (data_rvalid_i),
    .data_rdata_i   (data_rdata_i),
    .data_err_i     (data_err_i)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_data(input logic [lsu_pkg::DATA_W-1:0] got,
                            input logic [lsu_pkg::DATA_W-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("mismatch at %0t: rdata_o %h, expected %h", $time, got, exp));
  endtask

  task automatic check_addr(input logic [lsu_pkg::ADDR_W-1:0] got,
                            input logic [lsu_pkg::ADDR_W-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("mismatch at %0t: data_addr_o %h, expected %h", $time, got, exp));
  endtask

  task automatic check_be(input logic [lsu_pkg::BE_W-1:0] got,
                          input logic [lsu_pkg::BE_W-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("mismatch at %0t: data_be_o %b, expected %b", $time, got, exp));
  endtask

  task automatic check_err(input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("mismatch at %0t: err_o %b, expected %b", $time, got, exp));
  endtask

  // Pattern over the whole word index
  function automatic logic [lsu_pkg::DATA_W-1:0] fill_word(input int idx);
    return 32'(idx + 1) * 32'h9e37_79b9;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////////////////////////

  initial
  begin : memory_model
    int         due;
    int         last_due;
    logic [7:0] idx;
    last_due      = 0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    data_err_i    = 1'b0;
    for (int i = 0; i < 256; i++)
      mem[i] = fill_word(i);
    forever
    begin
      // Bus sampled mid cycle, as it stands at the coming edge
      @(negedge clk);
      cycle++;
      if (data_rvalid_i)
        outstanding--;
      if (data_req_o && data_gnt_i)
      begin
        if (exp_addr_q.size() == 0)
          abort_run("bus grant with no bus phase expected");
        check_addr(data_addr_o, exp_addr_q.pop_front());
        check_be(data_be_o, exp_be_q.pop_front());
        idx = data_addr_o[9:2];
        rsp_data_q.push_back(mem[idx]);
        rsp_err_q.push_back(err_next);
        // Response 1 to 3 cycles on, never ahead of an older one
        due = cycle + 1 + int'({$random(seed)} % 3);
        if (due <= last_due)
          due = last_due + 1;
        last_due = due;
        rsp_due_q.push_back(due);
        if (data_we_o)
        begin
          for (int b = 0; b < lsu_pkg::BE_W; b++)
            if (data_be_o[b])
              mem[idx][8*b +: 8] = data_wdata_o[8*b +: 8];
        end
        outstanding++;
        if (outstanding > MAX_OUT)
          abort_run("more bus transactions outstanding than the configured limit");
        gnt_wait = int'({$random(seed)} % 3);
      end
      else if (data_req_o && gnt_wait > 0)
        gnt_wait--;
      @(posedge clk);
      #1;
      data_gnt_i = (gnt_wait == 0);
      if (rsp_due_q.size() != 0 && rsp_due_q[0] == cycle)
      begin
        void'(rsp_due_q.pop_front());
        data_rvalid_i = 1'b1;
        data_rdata_i  = rsp_data_q.pop_front();
        data_err_i    = rsp_err_q.pop_front();
      end
      else
      begin
        data_rvalid_i = 1'b0;
        data_rdata_i  = '0;
        data_err_i    = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result monitor
  //////////////////////////////////////////////////////////////////////

  initial
  begin : result_monitor
    logic                       we;
    logic                       err;
    logic [lsu_pkg::DATA_W-1:0] exp;
    forever
    begin
      @(negedge clk);
      // Error flag follows each response
      err = 1'b0;
      if (data_rvalid_i)
      begin
        if (exp_err_q.size() == 0)
          abort_run("bus response with no bus phase pending");
        err = exp_err_q.pop_front();
      end
      check_err(err_o, err);
      if (result_valid_o)
      begin
        if (exp_we_q.size() == 0)
          abort_run("result_valid_o pulsed with no access pending");
        we  = exp_we_q.pop_front();
        exp = exp_data_q.pop_front();
        if (!we)
          check_data(rdata_o, exp);
        results++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Little endian byte update of the expected memory
  task automatic store_shadow(input logic [lsu_pkg::ADDR_W-1:0] addr,
                              input logic [lsu_pkg::TYPE_W-1:0] typ,
                              input logic [lsu_pkg::DATA_W-1:0] wdata);
    logic [lsu_pkg::ADDR_W-1:0] a;
    int                         n;
    n = (typ == lsu_pkg::LSU_BYTE) ? 1 : (typ == lsu_pkg::LSU_HALF) ? 2 : 4;
    for (int i = 0; i < n; i++)
    begin
      a = addr + 32'(i);
      shadow[a[9:2]][8*a[1:0] +: 8] = wdata[8*i +: 8];
    end
  endtask

  // One access, called 1 ns after a rising edge
  task automatic issue(input logic [lsu_pkg::ADDR_W-1:0] base,
                       input logic [lsu_pkg::ADDR_W-1:0] offs32,
                       input logic [lsu_pkg::TYPE_W-1:0] typ,
                       input logic                       sign,
                       input logic                       we,
                       input logic [lsu_pkg::DATA_W-1:0] wdata,
                       input logic                       err);
    logic [lsu_pkg::ADDR_W-1:0] addr;
    logic [lsu_pkg::OFFS_W-1:0] offs;
    logic [7:0]                 w;
    logic                       split;
    logic                       got;
    int                         n;
    addr  = base + offs32;
    offs  = addr[1:0];
    w     = addr[9:2];
    split = (typ == lsu_pkg::LSU_HALF) ? (offs == 2'd3)
                                       : (typ != lsu_pkg::LSU_BYTE && offs != 2'd0);
    exp_addr_q.push_back(addr);
    exp_be_q.push_back(ref_be(typ, offs, 1'b0));
    exp_err_q.push_back(err);
    // Second phase goes to the next aligned word
    if (split)
    begin
      exp_addr_q.push_back((addr & ~32'h3) + 32'h4);
      exp_be_q.push_back(ref_be(typ, offs, 1'b1));
      exp_err_q.push_back(err);
    end
    exp_we_q.push_back(we);
    exp_data_q.push_back(ref_load(shadow[w], shadow[w + 8'd1], offs, typ, sign));
    if (we)
      store_shadow(addr, typ, wdata);
    accesses++;
    err_next   = err;
    req_i      = 1'b1;
    base_i     = base;
    offset_i   = offs32;
    type_i     = typ;
    sign_ext_i = sign;
    we_i       = we;
    wdata_i    = wdata;
    n   = 0;
    got = 1'b0;
    // Ready sampled mid cycle, the handshake is the following edge
    while (!got)
    begin
      @(negedge clk);
      got = ready_o;
      n++;
      if (!got && busy_o !== 1'b1)
        abort_run($sformatf("mismatch at %0t: busy_o low while a request waits", $time));
      if (!got && n >= TIMEOUT)
        abort_run("timeout waiting for ready_o to accept a request");
    end
    @(posedge clk);
    #1;
    req_i    = 1'b0;
    err_next = 1'b0;
  endtask

  initial
  begin : stimulus
    logic [31:0] rnd;
    int          n;
    rst_n      = 1'b0;
    req_i      = 1'b0;
    base_i     = '0;
    offset_i   = '0;
    type_i     = lsu_pkg::LSU_BYTE;
    sign_ext_i = 1'b0;
    we_i       = 1'b0;
    wdata_i    = '0;
    for (int i = 0; i < 256; i++)
      shadow[i] = fill_word(i);
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    if (data_req_o !== 1'b0 || result_valid_o !== 1'b0 || err_o !== 1'b0 || busy_o !== 1'b0)
      abort_run($sformatf("mismatch at %0t: outputs not idle after reset", $time));

    // Aligned word store and readback
    issue(32'h40, 32'h0, lsu_pkg::LSU_WORD, 1'b0, 1'b1, 32'hcafe_f00d, 1'b0);
    issue(32'h40, 32'h0, lsu_pkg::LSU_WORD, 1'b0, 1'b0, 32'h0, 1'b0);

    // Loads of every size, offset and sign mode
    for (int t = 0; t < 3; t++)
      for (int o = 0; o < 4; o++)
        for (int s = 0; s < 2; s++)
          issue(32'h80 + 32'(16 * t), 32'(o), t[1:0], s[0], 1'b0, 32'h0, 1'b0);

    // Stores of every size and offset, each read back as two words
    for (int t = 0; t < 3; t++)
      for (int o = 0; o < 4; o++)
      begin
        rnd = $random(seed);
        issue(32'h100 + 32'(16 * t), 32'(o), t[1:0], 1'b0, 1'b1, rnd, 1'b0);
        issue(32'h100 + 32'(16 * t), 32'h0, lsu_pkg::LSU_WORD, 1'b0, 1'b0, 32'h0, 1'b0);
        issue(32'h104 + 32'(16 * t), 32'h0, lsu_pkg::LSU_WORD, 1'b0, 1'b0, 32'h0, 1'b0);
      end

    // Bus error on a load
    issue(32'h20, 32'h0, lsu_pkg::LSU_WORD, 1'b0, 1'b0, 32'h0, 1'b1);

    // Back to back random traffic, size code 3 included
    for (int k = 0; k < 80; k++)
    begin
      rnd = $random(seed);
      issue({22'd0, rnd[13:6], 2'b00}, {30'd0, rnd[3:2]}, rnd[1:0], rnd[5], rnd[4],
            $random(seed), rnd[17:15] == 3'd0);
    end

    // Wait for every response to return
    n = 0;
    while ((exp_we_q.size() != 0 || outstanding != 0) && n < TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    if (exp_we_q.size() != 0 || outstanding != 0)
      abort_run("timeout waiting for the last bus responses");
    @(negedge clk);
    if (exp_addr_q.size() != 0 || results != accesses)
      abort_run("run ended with bus phases or results missing");
    else if (busy_o !== 1'b0)
      abort_run($sformatf("mismatch at %0t: busy_o still high after the last response", $time));
    else
    begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

// File: verilog/lsu_top.sv
//////////////////////////////////////////////////////////////////////
// Load/store unit top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_top #(
  parameter int MAX_OUTSTANDING = lsu_pkg::DEF_MAX_OUTSTANDING
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // Core request
  input  logic                       req_i,
  input  logic [lsu_pkg::ADDR_W-1:0] base_i,
  input  logic [lsu_pkg::ADDR_W-1:0] offset_i,
  input  logic [lsu_pkg::TYPE_W-1:0] type_i,
  input  logic                       sign_ext_i,
  input  logic                       we_i,
  input  logic [lsu_pkg::DATA_W-1:0] wdata_i,
  output logic                       ready_o,
  output logic                       busy_o,
  // Core result
  output logic                       result_valid_o,
  output logic [lsu_pkg::DATA_W-1:0] rdata_o,
  output logic                       err_o,
  // Memory bus
  output logic                       data_req_o,
  input  logic                       data_gnt_i,
  output logic [lsu_pkg::ADDR_W-1:0] data_addr_o,
  output logic                       data_we_o,
  output logic [lsu_pkg::BE_W-1:0]   data_be_o,
  output logic [lsu_pkg::DATA_W-1:0] data_wdata_o,
  input  logic                       data_rvalid_i,
  input  logic [lsu_pkg::DATA_W-1:0] data_rdata_i,
  input  logic                       data_err_i
);

  logic ctrl_update;
  logic split_first;
  logic split_phase;

  assign data_we_o = we_i;

  // Address, enables and store data
  lsu_addr_gen addr_gen_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .base_i        (base_i),
    .offset_i      (offset_i),
    .type_i        (type_i),
    .wdata_i       (wdata_i),
    .ctrl_update_i (ctrl_update),
    .addr_o        (data_addr_o),
    .be_o          (data_be_o),
    .wdata_o       (data_wdata_o),
    .split_first_o (split_first),
    .split_phase_o (split_phase)
  );

  // Bus handshake and flow control
  lsu_txn_tracker #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) txn_tracker_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .split_first_i (split_first),
    .data_req_o    (data_req_o),
    .ctrl_update_o (ctrl_update),
    .ready_o       (ready_o),
    .busy_o        (busy_o)
  );

  lsu_rdata_align rdata_align_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl_update_i  (ctrl_update),
    .split_first_i  (split_first),
    .split_phase_i  (split_phase),
    .addr_i         (data_addr_o),
    .type_i         (type_i),
    .sign_ext_i     (sign_ext_i),
    .we_i           (we_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_rdata_i   (data_rdata_i),
    .data_err_i     (data_err_i),
    .result_valid_o (result_valid_o),
    .rdata_o        (rdata_o),
    .err_o          (err_o)
  );

endmodule

// File: verilog/lsu_rdata_align.sv
//////////////////////////////////////////////////////////////////////
// Load/store read data alignment
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_rdata_align (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       ctrl_update_i,
  input  logic                       split_first_i,
  input  logic                       split_phase_i,
  input  logic [lsu_pkg::ADDR_W-1:0] addr_i,
  input  logic [lsu_pkg::TYPE_W-1:0] type_i,
  input  logic                       sign_ext_i,
  input  logic                       we_i,
  input  logic                       data_rvalid_i,
  input  logic [lsu_pkg::DATA_W-1:0] data_rdata_i,
  input  logic                       data_err_i,
  output logic                       result_valid_o,
  output logic [lsu_pkg::DATA_W-1:0] rdata_o,
  output logic                       err_o
);

  // Info of the access whose response comes next
  logic [lsu_pkg::TYPE_W-1:0] type_q;
  logic                       sign_q;
  logic                       we_q;
  logic [lsu_pkg::OFFS_W-1:0] offs_q;
  logic                       last_q;

  // First half of a split load, or the last result
  logic [lsu_pkg::DATA_W-1:0] rdata_q;

  logic [7:0]                 byte_sel;
  logic [15:0]                half_sel;
  logic [lsu_pkg::DATA_W-1:0] word_sel;
  logic [lsu_pkg::DATA_W-1:0] rdata_ext;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      type_q <= lsu_pkg::LSU_BYTE;
      sign_q <= 1'b0;
      we_q   <= 1'b0;
      offs_q <= '0;
      last_q <= 1'b0;
    end
    else if (ctrl_update_i)
    begin
      type_q <= type_i;
      sign_q <= sign_ext_i;
      we_q   <= we_i;
      // Second phase address is word aligned, keep the original offset
      if (!split_phase_i)
        offs_q <= addr_i[lsu_pkg::OFFS_W-1:0];
      last_q <= !split_first_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Lane selection
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (offs_q)
      2'b00: byte_sel = data_rdata_i[7:0];
      2'b01: byte_sel = data_rdata_i[15:8];
      2'b10: byte_sel = data_rdata_i[23:16];
      2'b11: byte_sel = data_rdata_i[31:24];
    endcase
  end

  // Offset 3 joins the saved top byte with the new low byte
  always_comb
  begin
    case (offs_q)
      2'b00: half_sel = data_rdata_i[15:0];
      2'b01: half_sel = data_rdata_i[23:8];
      2'b10: half_sel = data_rdata_i[31:16];
      2'b11: half_sel = {data_rdata_i[7:0], rdata_q[31:24]};
    endcase
  end

  always_comb
  begin
    case (offs_q)
      2'b00: word_sel = data_rdata_i;
      2'b01: word_sel = {data_rdata_i[7:0], rdata_q[31:8]};
      2'b10: word_sel = {data_rdata_i[15:0], rdata_q[31:16]};
      2'b11: word_sel = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  // Zero or sign extension by access size
  always_comb
  begin
    case (type_q)
      lsu_pkg::LSU_BYTE: rdata_ext = {{(lsu_pkg::DATA_W-8){sign_q & byte_sel[7]}}, byte_sel};
      lsu_pkg::LSU_HALF: rdata_ext = {{(lsu_pkg::DATA_W-16){sign_q & half_sel[15]}}, half_sel};
      default:           rdata_ext = word_sel;
    endcase
  end

  // Raw word kept after a first phase for the join
  always_ff @(posedge clk)
  begin
    if (data_rvalid_i && !we_q)
      rdata_q <= last_q ? rdata_ext : data_rdata_i;
  end

  assign rdata_o        = rdata_ext;
  assign result_valid_o = data_rvalid_i && last_q;
  // Reported for either phase of a split
  assign err_o          = data_rvalid_i && data_err_i;

endmodule

// File: verilog/lsu_txn_tracker.sv
//////////////////////////////////////////////////////////////////////
// Load/store bus transaction tracker
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_txn_tracker #(
  parameter int MAX_OUTSTANDING = lsu_pkg::DEF_MAX_OUTSTANDING
) (
  input  logic clk,
  input  logic rst_n,
  input  logic req_i,
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  input  logic split_first_i,
  output logic data_req_o,
  output logic ctrl_update_o,
  output logic ready_o,
  output logic busy_o
);

  localparam int               CNT_W   = $clog2(MAX_OUTSTANDING + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(MAX_OUTSTANDING);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_next;
  logic             count_up;
  logic             count_down;
  // Current phase already granted, waiting for the older response
  logic             held_q;
  logic             granted;
  logic             prev_clear;
  logic             done;

  // Never request twice for one phase
  assign data_req_o = req_i && !held_q && (cnt_q < CNT_MAX);

  assign count_up   = data_req_o && data_gnt_i;
  assign count_down = data_rvalid_i;
  assign granted    = held_q || count_up;

  // Result path holds one access, so the older one must answer first
  assign prev_clear = (cnt_q == CNT_W'(held_q)) || data_rvalid_i;

  // Phase done once granted and the result path is free
  assign done          = !req_i || (granted && prev_clear);
  assign ctrl_update_o = req_i && done;

  // Core waits while the first half of a split is issued
  assign ready_o = done && !split_first_i;
  assign busy_o  = (cnt_q != '0) || data_req_o;

  //////////////////////////////////////////////////////////////////////
  // Outstanding count
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case ({count_up, count_down})
      2'b10:   cnt_next = cnt_q + 1'b1;
      2'b01:   cnt_next = cnt_q - 1'b1;
      default: cnt_next = cnt_q;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else
      cnt_q <= cnt_next;
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      held_q <= 1'b0;
    else if (ctrl_update_o || !req_i)
      held_q <= 1'b0;
    else if (count_up)
      held_q <= 1'b1;
  end

endmodule

// File: verilog/lsu_addr_gen.sv
//////////////////////////////////////////////////////////////////////
// Load/store address generation
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_addr_gen (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req_i,
  input  logic [lsu_pkg::ADDR_W-1:0] base_i,
  input  logic [lsu_pkg::ADDR_W-1:0] offset_i,
  input  logic [lsu_pkg::TYPE_W-1:0] type_i,
  input  logic [lsu_pkg::DATA_W-1:0] wdata_i,
  input  logic                       ctrl_update_i,
  output logic [lsu_pkg::ADDR_W-1:0] addr_o,
  output logic [lsu_pkg::BE_W-1:0]   be_o,
  output logic [lsu_pkg::DATA_W-1:0] wdata_o,
  output logic                       split_first_o,
  output logic                       split_phase_o
);

  logic [lsu_pkg::ADDR_W-1:0] addr_step;
  logic [lsu_pkg::ADDR_W-1:0] addr_int;
  logic [lsu_pkg::OFFS_W-1:0] offs;
  // Second bus phase of a split access in progress
  logic                       split_q;

  // Next word for the second phase
  assign addr_step = split_q ? {{(lsu_pkg::ADDR_W-3){1'b0}}, 3'b100} : '0;
  assign addr_int  = base_i + offset_i + addr_step;
  assign offs      = addr_int[lsu_pkg::OFFS_W-1:0];

  // Second phase starts at byte 0 of the next word
  assign addr_o = split_q ? {addr_int[lsu_pkg::ADDR_W-1:lsu_pkg::OFFS_W], {lsu_pkg::OFFS_W{1'b0}}}
                          : addr_int;

  //////////////////////////////////////////////////////////////////////
  // Byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (type_i)
      lsu_pkg::LSU_BYTE:
      begin
        case (offs)
          2'b00: be_o = 4'b0001;
          2'b01: be_o = 4'b0010;
          2'b10: be_o = 4'b0100;
          2'b11: be_o = 4'b1000;
        endcase
      end
      lsu_pkg::LSU_HALF:
      begin
        // Upper byte of a halfword at offset 3 lands in the next word
        if (split_q)
          be_o = 4'b0001;
        else
        begin
          case (offs)
            2'b00: be_o = 4'b0011;
            2'b01: be_o = 4'b0110;
            2'b10: be_o = 4'b1100;
            2'b11: be_o = 4'b1000;
          endcase
        end
      end
      default:
      begin
        // Word, low part in first phase and remainder after
        case ({split_q, offs})
          3'b000: be_o = 4'b1111;
          3'b001: be_o = 4'b1110;
          3'b010: be_o = 4'b1100;
          3'b011: be_o = 4'b1000;
          3'b100: be_o = 4'b0000;
          3'b101: be_o = 4'b0001;
          3'b110: be_o = 4'b0011;
          3'b111: be_o = 4'b0111;
        endcase
      end
    endcase
  end

  // Rotate store data so each byte sits on its lane
  always_comb
  begin
    case (offs)
      2'b00: wdata_o = wdata_i;
      2'b01: wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'b10: wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      2'b11: wdata_o = {wdata_i[7:0], wdata_i[31:8]};
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Split detection
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    split_first_o = 1'b0;
    if (req_i && !split_q)
    begin
      case (type_i)
        lsu_pkg::LSU_BYTE: split_first_o = 1'b0;
        lsu_pkg::LSU_HALF: split_first_o = (offs == 2'b11);
        default:           split_first_o = (offs != 2'b00);
      endcase
    end
  end

  // Cleared between requests so a new access always starts in phase one
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      split_q <= 1'b0;
    else if (!req_i)
      split_q <= 1'b0;
    else if (ctrl_update_i)
      split_q <= split_first_o;
  end

  assign split_phase_o = split_q;

endmodule

// File: verilog/lsu_pkg.sv
//////////////////////////////////////////////////////////////////////
// Load/store unit shared definitions
//////////////////////////////////////////////////////////////////////

package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////

  // Byte address on the memory bus
  localparam int ADDR_W = 32;

  // Read and write data word
  localparam int DATA_W = 32;

  // One enable per data byte
  localparam int BE_W = DATA_W / 8;

  // Byte position inside a word
  localparam int OFFS_W = $clog2(BE_W);

  //////////////////////////////////////////////////////////////////////
  // Access size
  //////////////////////////////////////////////////////////////////////

  localparam int TYPE_W = 2;

  // Size codes as driven by the core
  localparam logic [TYPE_W-1:0] LSU_BYTE = 2'd0;
  localparam logic [TYPE_W-1:0] LSU_HALF = 2'd1;
  localparam logic [TYPE_W-1:0] LSU_WORD = 2'd2;
  // Code 3 falls back to a word access

  //////////////////////////////////////////////////////////////////////
  // Bus pipelining
  //////////////////////////////////////////////////////////////////////

  // Granted transactions that may wait for a response
  localparam int DEF_MAX_OUTSTANDING = 2;

endpackage
